//--- run.sh
#!/bin/sh
# build and run the Fletcher-32 checksum testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module ChecksumTb \
    -f verilog.f \
    -o ChecksumSim

# a $fatal run exits nonzero, the output still gets searched
simOut=$(./obj_dir/ChecksumSim) || true
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qx "STATUS: PASS"; then
    exit 0
else
    exit 1
fi

//--- sim/ChecksumTb.sv
`timescale 1ns/1ps

module ChecksumTb;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          cmdValid;
    ChecksumPkg::cmdOpT            cmdOp;
    logic [ChecksumPkg::WordW-1:0] cmdData;
    logic                          sumCredit;
    logic                          cmdCredit;
    logic                          sumValid;
    logic [ChecksumPkg::SumW-1:0]  sum;

    // driver bookkeeping for the stimulus process
    int                            sentCount = 0;
    logic [ChecksumPkg::WordW-1:0] msgWords [$];
    logic [ChecksumPkg::SumW-1:0]  expMem [512];
    int                            expWr = 0;
    logic                          holdSink;

    // monitor bookkeeping
    int creditCount = 0;
    int expRd = 0;
    int received = 0;

    // sink bookkeeping
    int returned = 0;

    ChecksumTop dut0 (
        .clk       (clk),
        .rst       (rst),
        .cmdValid  (cmdValid),
        .cmdOp     (cmdOp),
        .cmdData   (cmdData),
        .sumCredit (sumCredit),
        .cmdCredit (cmdCredit),
        .sumValid  (sumValid),
        .sum       (sum)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    // plain Fletcher-32 over 16-bit words with b in the upper half
    function automatic logic [31:0] fletcherRef(input logic [15:0] words [$]);
        int unsigned a;
        int unsigned b;
        a = 0;
        b = 0;
        foreach (words[i]) begin
            a = (a + 32'(words[i])) % ChecksumPkg::Modulus;
            b = (b + a) % ChecksumPkg::Modulus;
        end
        return {b[15:0], a[15:0]};
    endfunction

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            stopOnError($sformatf("error: time %0t, %s: got 0x%08h, expected 0x%08h",
                                  $time, name, got, exp));
        end
    endtask

    // one command per call entered and left at a falling edge
    task automatic sendCmd(input ChecksumPkg::cmdOpT opCode, input logic [15:0] word);
        int waitCycles;
        waitCycles = 0;
        // wait for a free input credit
        while ((sentCount - creditCount) >= ChecksumPkg::InCredits && waitCycles < 2000) begin
            @(negedge clk);
            waitCycles++;
        end
        if ((sentCount - creditCount) >= ChecksumPkg::InCredits) begin
            stopOnError("timeout: no input credit came back within 2000 cycles");
        end
        cmdValid  = 1'b1;
        cmdOp     = opCode;
        cmdData   = word;
        sentCount++;
        @(negedge clk);
        cmdValid = 1'b0;
    endtask

    task automatic sendData(input logic [15:0] word);
        msgWords.push_back(word);
        sendCmd(ChecksumPkg::opData, word);
    endtask

    task automatic sendClear();
        msgWords.delete();
        sendCmd(ChecksumPkg::opClear, 16'h0000);
    endtask

    // expected value is queued before the finish goes out
    task automatic sendFinish();
        expMem[expWr[8:0]] = fletcherRef(msgWords);
        expWr++;
        msgWords.delete();
        sendCmd(ChecksumPkg::opFinish, 16'h0000);
    endtask

    // unused opcode that decode drops but still credits
    task automatic sendUnused(input logic [15:0] word);
        sendCmd(ChecksumPkg::cmdOpT'(2'd3), word);
    endtask

    task automatic sendRandomMessage(input int maxWords);
        int nWords;
        logic [15:0] word;
        nWords = $urandom % (maxWords + 1);
        for (int i = 0; i < nWords; i++) begin
            word = 16'($urandom);
            // extra 0xFFFF words for the residue fold
            if ($urandom % 8 == 0) begin
                word = 16'hffff;
            end
            sendData(word);
            if ($urandom % 16 == 0) begin
                sendUnused(word);
            end
        end
        sendFinish();
    endtask

    // compare process sampling outputs at the edge that consumes them
    always @(posedge clk) begin
        if (!rst) begin
            if (cmdCredit) begin
                creditCount++;
                if (creditCount > sentCount) begin
                    stopOnError("cmdCredit pulse with no outstanding command");
                end
            end
            if (sumValid) begin
                if (expRd >= expWr) begin
                    stopOnError("sumValid with no checksum expected");
                end else begin
                    checkValue("sum", sum, expMem[expRd[8:0]]);
                    expRd++;
                    received++;
                end
                if ((received - returned) > ChecksumPkg::OutCredits) begin
                    stopOnError("more checksums outstanding than output credits given");
                end
            end
        end
    end

    // sink returning one credit per checksum after a random delay
    initial begin
        int delay;
        sumCredit = 1'b0;
        delay = 0;
        forever begin
            @(negedge clk);
            sumCredit = 1'b0;
            if (!holdSink && returned < received) begin
                if (delay > 0) begin
                    delay--;
                end else begin
                    sumCredit = 1'b1;
                    returned++;
                    delay = $urandom % 21;
                end
            end
        end
    end

    initial begin
        int waitCycles;
        logic [15:0] dirWords [$];
        void'($urandom(32'h0c51_2c04));
        rst      = 1'b1;
        cmdValid = 1'b0;
        cmdOp    = ChecksumPkg::opClear;
        cmdData  = '0;
        holdSink = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // directed message then an empty one
        dirWords = '{16'h0102, 16'h0304, 16'h0506};
        checkValue("fletcherRef", fletcherRef(dirWords), 32'h0e14_090c);
        foreach (dirWords[i]) begin
            sendData(dirWords[i]);
        end
        sendFinish();
        sendFinish();

        // clear mid-message right behind a data word
        sendData(16'h1111);
        sendData(16'h2222);
        sendData(16'h3333);
        sendClear();
        sendData(16'h4444);
        sendData(16'h5555);
        sendFinish();
        sendClear();
        sendFinish();

        // residue fold with 0xFFFF words
        sendData(16'h0001);
        sendData(16'hffff);
        sendData(16'h0002);
        sendData(16'hffff);
        sendData(16'hfffe);
        sendFinish();
        repeat (60) sendData(16'hffff);
        sendFinish();
        sendData(16'h1234);
        repeat (30) sendData(16'hffff);
        sendData(16'hfffe);
        sendFinish();

        // random messages back-to-back
        repeat (200) sendRandomMessage(40);

        // output back-pressure with sink credits withheld in long stretches
        fork
            begin
                repeat (10) sendRandomMessage(6);
            end
            begin
                @(posedge clk);
                holdSink = 1'b1;
                repeat (200) @(posedge clk);
                holdSink = 1'b0;
                repeat (5) @(posedge clk);
                holdSink = 1'b1;
                repeat (200) @(posedge clk);
                holdSink = 1'b0;
            end
        join

        // drain all checksums and credits
        waitCycles = 0;
        while ((expRd < expWr || creditCount < sentCount || returned < received)
               && waitCycles < 5000) begin
            @(negedge clk);
            waitCycles++;
        end
        if (expRd < expWr) begin
            stopOnError("timeout: expected checksums never appeared on sumValid");
        end

        if (creditCount == sentCount && returned == received) begin
            $display("commands %0d, checksums %0d", sentCount, received);
            $display("STATUS: PASS");
            $finish;
        end else begin
            stopOnError("input or output credits did not return to their initial count");
        end
    end

endmodule

//--- verilog.f
verilog/ChecksumPkg.sv
verilog/CmdDecode.sv
verilog/FletcherExec.sv
verilog/ChecksumResult.sv
verilog/ChecksumTop.sv
sim/ChecksumTb.sv

//--- verilog/ChecksumPkg.sv
package ChecksumPkg;

    // command opcodes carried on the input channel
    // code 2'd3 is unused and gets dropped at the decode head
    typedef enum logic [1:0] {
        opClear  = 2'd0,
        opData   = 2'd1,
        opFinish = 2'd2
    } cmdOpT;

    // input data word width
    localparam int WordW = 16;

    // checksum width, b in the upper half, a in the lower half
    localparam int SumW = 32;

    // accumulator width, one extra bit for the sign of the reduced candidate
    localparam int AccW = WordW + 1;

    // Fletcher-32 modulus
    localparam int unsigned Modulus = 65535;

    // modulus at accumulator width
    localparam logic [AccW-1:0] ModulusAcc = (AccW)'(Modulus);

    // decode queue depth, also the source's credits after reset
    localparam int InCredits = 4;

    // checksums the sink can hold, result block starts with this many credits
    localparam int OutCredits = 2;

    // result queue depth
    localparam int ResultDepth = 2;

    // pointer and counter widths
    // both queue depths are powers of two so pointers wrap on their own
    localparam int InPtrW = $clog2(InCredits);
    localparam int InCountW = $clog2(InCredits + 1);
    localparam int ResPtrW = $clog2(ResultDepth);
    localparam int ResCountW = $clog2(ResultDepth + 1);
    localparam int OutCreditW = $clog2(OutCredits + 1);

endpackage

//--- verilog/ChecksumResult.sv
`timescale 1ns/1ps

module ChecksumResult (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            chkValid,
    input  logic [ChecksumPkg::SumW-1:0]    chk,
    input  logic                            sumCredit,
    output logic                            resultSpace,
    output logic                            sumValid,
    output logic [ChecksumPkg::SumW-1:0]    sum
);

    // checksum queue storage
    logic [ChecksumPkg::SumW-1:0] mem [ChecksumPkg::ResultDepth];

    logic [ChecksumPkg::ResPtrW-1:0]    wrPtr;
    logic [ChecksumPkg::ResPtrW-1:0]    rdPtr;
    logic [ChecksumPkg::ResCountW-1:0]  count;

    // checksums the sink can still take
    logic [ChecksumPkg::OutCreditW-1:0] credits;

    // occupancy once this cycle's push and send have landed
    logic [ChecksumPkg::ResCountW:0] occAfter;

    logic send;

    // head goes out whenever there is an entry and a credit
    assign send = (count != '0) && (credits != '0);

    assign sumValid = send;
    assign sum      = mem[rdPtr];

    assign occAfter = {1'b0, count} + {{ChecksumPkg::ResCountW{1'b0}}, chkValid}
                    - {{ChecksumPkg::ResCountW{1'b0}}, send};

    // execute samples this at the edge that launches its chk,
    // the entry then lands one edge later
    assign resultSpace = (occAfter < ChecksumPkg::ResultDepth);

    always_ff @(posedge clk) begin
        if (chkValid) begin
            mem[wrPtr] <= chk;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            credits <= ChecksumPkg::OutCreditW'(ChecksumPkg::OutCredits);
        end else begin
            if (chkValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (send) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // queue occupancy
            case ({chkValid, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // spend one per send, regain one per returned credit
            case ({send, sumCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- verilog/ChecksumTop.sv
`timescale 1ns/1ps

module ChecksumTop (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmdValid,
    input  ChecksumPkg::cmdOpT              cmdOp,
    input  logic [ChecksumPkg::WordW-1:0]   cmdData,
    input  logic                            sumCredit,
    output logic                            cmdCredit,
    output logic                            sumValid,
    output logic [ChecksumPkg::SumW-1:0]    sum
);

    // decode to execute
    logic                           opValid;
    ChecksumPkg::cmdOpT             op;
    logic [ChecksumPkg::WordW-1:0]  opData;
    logic                           execReady;

    // execute to result
    logic                           chkValid;
    logic [ChecksumPkg::SumW-1:0]   chk;
    logic                           resultSpace;

    // command queue, input credits
    CmdDecode decode0 (
        .clk       (clk),
        .rst       (rst),
        .cmdValid  (cmdValid),
        .cmdOp     (cmdOp),
        .cmdData   (cmdData),
        .execReady (execReady),
        .cmdCredit (cmdCredit),
        .opValid   (opValid),
        .op        (op),
        .opData    (opData)
    );

    // accumulators
    FletcherExec exec0 (
        .clk         (clk),
        .rst         (rst),
        .opValid     (opValid),
        .op          (op),
        .opData      (opData),
        .resultSpace (resultSpace),
        .execReady   (execReady),
        .chkValid    (chkValid),
        .chk         (chk)
    );

    // checksum queue, output credits
    ChecksumResult result0 (
        .clk         (clk),
        .rst         (rst),
        .chkValid    (chkValid),
        .chk         (chk),
        .sumCredit   (sumCredit),
        .resultSpace (resultSpace),
        .sumValid    (sumValid),
        .sum         (sum)
    );

endmodule

//--- verilog/CmdDecode.sv
`timescale 1ns/1ps

module CmdDecode (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmdValid,
    input  ChecksumPkg::cmdOpT              cmdOp,
    input  logic [ChecksumPkg::WordW-1:0]   cmdData,
    input  logic                            execReady,
    output logic                            cmdCredit,
    output logic                            opValid,
    output ChecksumPkg::cmdOpT              op,
    output logic [ChecksumPkg::WordW-1:0]   opData
);

    // queue storage
    ChecksumPkg::cmdOpT               opMem   [ChecksumPkg::InCredits];
    logic [ChecksumPkg::WordW-1:0]    dataMem [ChecksumPkg::InCredits];

    logic [ChecksumPkg::InPtrW-1:0]   wrPtr;
    logic [ChecksumPkg::InPtrW-1:0]   rdPtr;
    logic [ChecksumPkg::InCountW-1:0] count;

    logic headValid;
    logic headKnown;
    logic pop;

    // head entry of the queue
    assign op     = opMem[rdPtr];
    assign opData = dataMem[rdPtr];

    assign headValid = (count != '0);

    // only the three defined opcodes go on to execute
    assign headKnown = op inside {ChecksumPkg::opClear, ChecksumPkg::opData,
                                  ChecksumPkg::opFinish};

    assign opValid = headValid && headKnown;

    // transfer to execute or discard of an unknown opcode
    assign pop = (opValid && execReady) || (headValid && !headKnown);

    // source only sends with a credit so a push never hits a full queue
    always_ff @(posedge clk) begin
        if (cmdValid) begin
            opMem[wrPtr]   <= cmdOp;
            dataMem[wrPtr] <= cmdData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            cmdCredit <= 1'b0;
        end else begin
            if (cmdValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // push and pop may coincide
            case ({cmdValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per removed entry including dropped ones
            cmdCredit <= pop;
        end
    end

endmodule

//--- verilog/FletcherExec.sv
`timescale 1ns/1ps

module FletcherExec (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            opValid,
    input  ChecksumPkg::cmdOpT              op,
    input  logic [ChecksumPkg::WordW-1:0]   opData,
    input  logic                            resultSpace,
    output logic                            execReady,
    output logic                            chkValid,
    output logic [ChecksumPkg::SumW-1:0]    chk
);

    // finish sequencing
    // execFinish marks a finish held at the head waiting to complete
    typedef enum logic {
        execRun,
        execFinish
    } execStateT;

    execStateT state;

    // two candidates per sum, raw and raw minus modulus
    logic [ChecksumPkg::AccW-1:0] aRaw;
    logic [ChecksumPkg::AccW-1:0] aRed;
    logic [ChecksumPkg::AccW-1:0] bRaw;
    logic [ChecksumPkg::AccW-1:0] bRed;

    // pending b update, b runs one cycle behind a
    logic lag;

    logic [ChecksumPkg::WordW-1:0] aLive;
    logic [ChecksumPkg::WordW-1:0] bLive;
    logic [ChecksumPkg::AccW-1:0]  aNext;
    logic [ChecksumPkg::AccW-1:0]  bNext;

    logic isFinish;
    logic finishReady;
    logic accept;

    // negative reduced candidate means raw is already below the modulus
    assign aLive = aRed[ChecksumPkg::WordW] ? aRaw[ChecksumPkg::WordW-1:0]
                                            : aRed[ChecksumPkg::WordW-1:0];
    assign bLive = bRed[ChecksumPkg::WordW] ? bRaw[ChecksumPkg::WordW-1:0]
                                            : bRed[ChecksumPkg::WordW-1:0];

    // end-around-carry sums, residues stay in 0..65534
    assign aNext = {1'b0, aLive} + {1'b0, opData};
    assign bNext = {1'b0, bLive} + {1'b0, aLive};

    assign isFinish = (op == ChecksumPkg::opFinish);

    // finish waits for b to catch up and for room in the result queue
    assign finishReady = resultSpace && (!lag || state == execFinish);

    // data and clear are always taken
    assign execReady = !isFinish || finishReady;

    assign accept = opValid && execReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= execRun;
        end else if (accept) begin
            state <= execRun;
        end else if (opValid && isFinish) begin
            // stalled finish, the b update drains on this edge
            state <= execFinish;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aRaw     <= '0;
            aRed     <= '0;
            bRaw     <= '0;
            bRed     <= '0;
            lag      <= 1'b0;
            chkValid <= 1'b0;
        end else begin
            chkValid <= 1'b0;
            lag      <= accept && (op == ChecksumPkg::opData);
            // b picks up the a written one edge earlier
            if (lag) begin
                bRaw <= bNext;
                bRed <= bNext - ChecksumPkg::ModulusAcc;
            end
            if (accept) begin
                case (op)
                    ChecksumPkg::opData: begin
                        aRaw <= aNext;
                        aRed <= aNext - ChecksumPkg::ModulusAcc;
                    end
                    ChecksumPkg::opClear: begin
                        // also drops a pending b update
                        aRaw <= '0;
                        aRed <= '0;
                        bRaw <= '0;
                        bRed <= '0;
                    end
                    ChecksumPkg::opFinish: begin
                        aRaw     <= '0;
                        aRed     <= '0;
                        bRaw     <= '0;
                        bRed     <= '0;
                        chkValid <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // checksum payload captured with the finish
    always_ff @(posedge clk) begin
        if (accept && isFinish) begin
            chk <= {bLive, aLive};
        end
    end

endmodule
